//--- hdl/ethpipe_pkg.sv
package ethpipe_pkg;

  // --------------------------------------------------------------------------
  // bus and datapath widths
  // --------------------------------------------------------------------------
  localparam int AXI_ADDR_W   = 8;
  localparam int AXI_DATA_W   = 32;
  localparam int AXI_STRB_W   = 4;
  localparam int COUNTER_W    = 64;
  localparam int LOCAL_TIME_W = 48;
  localparam int TX_PTR_W     = 14;
  localparam int DMA_LEN_W    = 22;
  localparam int DMA_ADDR_W   = 32;
  localparam int STATUS_W     = 8;
  // slot index in the local time window, up to 8 slots
  localparam int SLOT_IDX_W   = 3;

  // --------------------------------------------------------------------------
  // register map, byte offsets
  // --------------------------------------------------------------------------
  localparam logic [AXI_ADDR_W-1:0] REG_COUNTER_LO      = 8'h00;
  localparam logic [AXI_ADDR_W-1:0] REG_COUNTER_HI      = 8'h04;
  localparam logic [AXI_ADDR_W-1:0] REG_DMA_STATUS      = 8'h08;
  localparam logic [AXI_ADDR_W-1:0] REG_DMA_LENGTH      = 8'h0C;
  localparam logic [AXI_ADDR_W-1:0] REG_DMA_START       = 8'h10;
  localparam logic [AXI_ADDR_W-1:0] REG_TX_WR_PTR       = 8'h18;
  localparam logic [AXI_ADDR_W-1:0] REG_TX_RD_PTR       = 8'h1C;
  // slot n: low word at base + 8n, high 16 bits at base + 8n + 4
  localparam logic [AXI_ADDR_W-1:0] REG_LOCAL_TIME_BASE = 8'h80;

  localparam int STATUS_RX_EVENT_BIT = 3;

  localparam logic [DMA_LEN_W-1:0]  DMA_LENGTH_RST = 22'h01_0000;
  localparam logic [DMA_ADDR_W-1:0] DMA_START_RST  = 32'h1000_0000;

  localparam logic [1:0] RESP_OKAY = 2'b00;

  // byte-lane merge of a bus write into an existing word
  function automatic logic [AXI_DATA_W-1:0] byte_merge(
    input logic [AXI_DATA_W-1:0] old_word,
    input logic [AXI_DATA_W-1:0] new_word,
    input logic [AXI_STRB_W-1:0] strb
  );
    logic [AXI_DATA_W-1:0] res;
    res = old_word;
    for (int b = 0; b < AXI_STRB_W; b++) begin
      if (strb[b]) res[b*8 +: 8] = new_word[b*8 +: 8];
    end
    return res;
  endfunction

endpackage

//--- hdl/global_timer.sv
module global_timer
  import ethpipe_pkg::*;
(
  input  logic                 clk_125,
  input  logic                 sys_rst,
  output logic [COUNTER_W-1:0] count_o
);

  logic [COUNTER_W-1:0] count_q;

  // system time base, shared by register reads and slot stamping
  // first cycle after reset reads zero
  always_ff @(posedge clk_125) begin
    if (sys_rst) begin
      count_q <= '0;
    end else begin
      count_q <= count_q + 1'b1;
    end
  end

  assign count_o = count_q;

endmodule

//--- hdl/axil_slave_fsm.sv
module axil_slave_fsm
  import ethpipe_pkg::*;
(
  input  logic                  clk_125,
  input  logic                  sys_rst,
  // write address channel
  input  logic [AXI_ADDR_W-1:0] axil_awaddr_i,
  input  logic                  axil_awvalid_i,
  output logic                  axil_awready_o,
  // write data channel
  input  logic [AXI_DATA_W-1:0] axil_wdata_i,
  input  logic [AXI_STRB_W-1:0] axil_wstrb_i,
  input  logic                  axil_wvalid_i,
  output logic                  axil_wready_o,
  // write response channel
  output logic [1:0]            axil_bresp_o,
  output logic                  axil_bvalid_o,
  input  logic                  axil_bready_i,
  // read address channel
  input  logic [AXI_ADDR_W-1:0] axil_araddr_i,
  input  logic                  axil_arvalid_i,
  output logic                  axil_arready_o,
  // read data channel
  output logic [AXI_DATA_W-1:0] axil_rdata_o,
  output logic [1:0]            axil_rresp_o,
  output logic                  axil_rvalid_o,
  input  logic                  axil_rready_i,
  // register strobes
  output logic                  reg_wr_o,
  output logic                  reg_rd_o,
  output logic [AXI_ADDR_W-1:0] reg_addr_o,
  output logic [AXI_DATA_W-1:0] reg_wdata_o,
  output logic [AXI_STRB_W-1:0] reg_wstrb_o,
  input  logic [AXI_DATA_W-1:0] reg_rdata_i
);

  localparam logic [1:0] ST_IDLE    = 2'd0;
  localparam logic [1:0] ST_WR_RESP = 2'd1;
  localparam logic [1:0] ST_RD_RESP = 2'd2;

  logic [1:0]            state;
  logic                  idle;
  logic                  wr_pending;
  logic                  wr_acc;
  logic                  rd_acc;
  logic [AXI_DATA_W-1:0] rdata_q;

  // --------------------------------------------------------------------------
  // acceptance, writes win ties
  // --------------------------------------------------------------------------
  assign idle       = (state == ST_IDLE);
  assign wr_pending = axil_awvalid_i | axil_wvalid_i;
  assign wr_acc     = idle & axil_awvalid_i & axil_wvalid_i;
  assign rd_acc     = idle & axil_arvalid_i & ~wr_pending;

  // address and data are taken together
  assign axil_awready_o = wr_acc;
  assign axil_wready_o  = wr_acc;
  assign axil_arready_o = idle & ~wr_pending;

  // strobes live only for the accept cycle
  assign reg_wr_o    = wr_acc;
  assign reg_rd_o    = rd_acc;
  assign reg_addr_o  = wr_acc ? axil_awaddr_i : axil_araddr_i;
  assign reg_wdata_o = axil_wdata_i;
  assign reg_wstrb_o = axil_wstrb_i;

  always_ff @(posedge clk_125) begin
    if (sys_rst) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (wr_acc) state <= ST_WR_RESP;
          else if (rd_acc) state <= ST_RD_RESP;
        end
        ST_WR_RESP: if (axil_bready_i) state <= ST_IDLE;
        ST_RD_RESP: if (axil_rready_i) state <= ST_IDLE;
        default: state <= ST_IDLE;
      endcase
    end
  end

  // read word captured on the accept edge, held until rready
  always_ff @(posedge clk_125) begin
    if (rd_acc) rdata_q <= reg_rdata_i;
  end

  // --------------------------------------------------------------------------
  // response channels
  // --------------------------------------------------------------------------
  assign axil_bvalid_o = (state == ST_WR_RESP);
  assign axil_bresp_o  = RESP_OKAY;
  assign axil_rvalid_o = (state == ST_RD_RESP);
  assign axil_rresp_o  = RESP_OKAY;
  assign axil_rdata_o  = rdata_q;

endmodule

//--- hdl/ctrl_regs.sv
module ctrl_regs
  import ethpipe_pkg::*;
#(
  parameter int NUM_SLOTS = 7
) (
  input  logic                  clk_125,
  input  logic                  sys_rst,
  // register strobes from the bus slave
  input  logic                  reg_wr_i,
  input  logic                  reg_rd_i,
  input  logic [AXI_ADDR_W-1:0] reg_addr_i,
  input  logic [AXI_DATA_W-1:0] reg_wdata_i,
  input  logic [AXI_STRB_W-1:0] reg_wstrb_i,
  output logic [AXI_DATA_W-1:0] reg_rdata_o,
  input  logic [COUNTER_W-1:0]  count_i,
  input  logic                  rx_event_i,
  input  logic [TX_PTR_W-1:0]   tx_rd_ptr_i,
  // local time slot port
  output logic                  slot_wr_o,
  output logic [SLOT_IDX_W-1:0] slot_idx_o,
  output logic                  slot_hi_o,
  output logic [AXI_DATA_W-1:0] slot_wdata_o,
  output logic [AXI_STRB_W-1:0] slot_wstrb_o,
  input  logic [AXI_DATA_W-1:0] slot_rdata_i,
  // DMA and transmit control
  output logic [DMA_LEN_W-1:0]  dma_length_o,
  output logic [DMA_ADDR_W-1:0] dma_start_o,
  output logic                  dma_load_o,
  output logic [TX_PTR_W-1:0]   tx_wr_ptr_o,
  output logic                  sys_intr_o
);

  logic [STATUS_W-1:0]     dma_status;
  logic [DMA_LEN_W-1:2]    dma_length;
  logic [DMA_ADDR_W-1:2]   dma_start;
  logic [TX_PTR_W-1:0]     tx_wr_ptr;
  logic                    dma_load;
  logic [AXI_ADDR_W-3:0]   word_addr;
  logic                    slot_hit;
  logic [AXI_DATA_W-1:0]   status_nxt;
  logic [AXI_DATA_W-1:0]   length_nxt;
  logic [AXI_DATA_W-1:0]   start_nxt;
  logic [AXI_DATA_W-1:0]   wr_ptr_nxt;
  logic [AXI_DATA_W-1:0]   rd_word;

  assign word_addr = reg_addr_i[AXI_ADDR_W-1:2];

  // local time window, 8 bytes per slot
  assign slot_hit = (reg_addr_i[7:6] == REG_LOCAL_TIME_BASE[7:6]) &&
                    ({1'b0, reg_addr_i[5:3]} < NUM_SLOTS);

  assign slot_wr_o    = reg_wr_i & slot_hit;
  assign slot_idx_o   = reg_addr_i[5:3];
  assign slot_hi_o    = reg_addr_i[2];
  assign slot_wdata_o = reg_wdata_i;
  assign slot_wstrb_o = reg_wstrb_i;

  // --------------------------------------------------------------------------
  // write side
  // --------------------------------------------------------------------------
  always_comb begin
    status_nxt = byte_merge({{(AXI_DATA_W-STATUS_W){1'b0}}, dma_status},
                            reg_wdata_i, reg_wstrb_i);
    length_nxt = byte_merge({{(AXI_DATA_W-DMA_LEN_W){1'b0}}, dma_length, 2'b00},
                            reg_wdata_i, reg_wstrb_i);
    start_nxt  = byte_merge({dma_start, 2'b00}, reg_wdata_i, reg_wstrb_i);
    wr_ptr_nxt = byte_merge({{(AXI_DATA_W-TX_PTR_W){1'b0}}, tx_wr_ptr},
                            reg_wdata_i, reg_wstrb_i);
  end

  always_ff @(posedge clk_125) begin
    if (sys_rst) begin
      dma_status <= '0;
      dma_length <= DMA_LENGTH_RST[DMA_LEN_W-1:2];
      dma_start  <= DMA_START_RST[DMA_ADDR_W-1:2];
      tx_wr_ptr  <= '0;
      dma_load   <= 1'b0;
    end else begin
      dma_load <= 1'b0;
      if (reg_wr_i) begin
        case (word_addr)
          REG_DMA_STATUS[AXI_ADDR_W-1:2]: dma_status <= status_nxt[STATUS_W-1:0];
          REG_DMA_LENGTH[AXI_ADDR_W-1:2]: begin
            dma_length <= length_nxt[DMA_LEN_W-1:2];
            dma_load   <= 1'b1;
          end
          REG_DMA_START[AXI_ADDR_W-1:2]: begin
            dma_start <= start_nxt[DMA_ADDR_W-1:2];
            dma_load  <= 1'b1;
          end
          REG_TX_WR_PTR[AXI_ADDR_W-1:2]: tx_wr_ptr <= wr_ptr_nxt[TX_PTR_W-1:0];
          default: ;
        endcase
      end
      // receive event beats a same-cycle status write
      if (rx_event_i) dma_status[STATUS_RX_EVENT_BIT] <= 1'b1;
    end
  end

  // --------------------------------------------------------------------------
  // read side
  // --------------------------------------------------------------------------
  always_comb begin
    rd_word = '0;
    if (slot_hit) begin
      rd_word = slot_rdata_i;
    end else begin
      case (word_addr)
        REG_COUNTER_LO[AXI_ADDR_W-1:2]: rd_word = count_i[31:0];
        REG_COUNTER_HI[AXI_ADDR_W-1:2]: rd_word = count_i[COUNTER_W-1:32];
        REG_DMA_STATUS[AXI_ADDR_W-1:2]: rd_word[STATUS_W-1:0] = dma_status;
        REG_DMA_LENGTH[AXI_ADDR_W-1:2]: rd_word[DMA_LEN_W-1:0] = {dma_length, 2'b00};
        REG_DMA_START[AXI_ADDR_W-1:2]:  rd_word = {dma_start, 2'b00};
        REG_TX_WR_PTR[AXI_ADDR_W-1:2]:  rd_word[TX_PTR_W-1:0] = tx_wr_ptr;
        REG_TX_RD_PTR[AXI_ADDR_W-1:2]:  rd_word[TX_PTR_W-1:0] = tx_rd_ptr_i;
        default: rd_word = '0;
      endcase
    end
  end

  // only a read strobe puts a word on the return path
  assign reg_rdata_o = reg_rd_i ? rd_word : '0;

  assign dma_length_o = {dma_length, 2'b00};
  assign dma_start_o  = {dma_start, 2'b00};
  assign dma_load_o   = dma_load;
  assign tx_wr_ptr_o  = tx_wr_ptr;
  assign sys_intr_o   = dma_status[STATUS_RX_EVENT_BIT];

endmodule

//--- hdl/local_time_capture.sv
module local_time_capture
  import ethpipe_pkg::*;
#(
  parameter int                      NUM_SLOTS   = 7,
  parameter logic [LOCAL_TIME_W-1:0] CAPTURE_ADJ = 48'd3
) (
  input  logic                  clk_125,
  input  logic                  sys_rst,
  input  logic [COUNTER_W-1:0]  count_i,
  input  logic [NUM_SLOTS-1:0]  time_req_i,
  input  logic                  slot_wr_i,
  input  logic [SLOT_IDX_W-1:0] slot_idx_i,
  input  logic                  slot_hi_i,
  input  logic [AXI_DATA_W-1:0] slot_wdata_i,
  input  logic [AXI_STRB_W-1:0] slot_wstrb_i,
  output logic [AXI_DATA_W-1:0] slot_rdata_o
);

  logic [LOCAL_TIME_W-1:0] slot_q [NUM_SLOTS];
  logic [NUM_SLOTS-1:0]    pending;
  logic [NUM_SLOTS-1:0]    stamp_sel;
  logic [LOCAL_TIME_W-1:0] stamp_val;
  logic [AXI_DATA_W-1:0]   cur_word;
  logic [AXI_DATA_W-1:0]   merged_word;

  // stamp the lowest pending slot unless software writes a slot
  assign stamp_sel = slot_wr_i ? '0 : (pending & (~pending + 1'b1));
  assign stamp_val = count_i[LOCAL_TIME_W-1:0] - CAPTURE_ADJ;

  // addressed word with the high half zero-extended to 32 bits
  always_comb begin
    cur_word = '0;
    if ({1'b0, slot_idx_i} < NUM_SLOTS) begin
      if (slot_hi_i) cur_word[LOCAL_TIME_W-33:0] = slot_q[slot_idx_i][LOCAL_TIME_W-1:32];
      else cur_word = slot_q[slot_idx_i][31:0];
    end
    merged_word = byte_merge(cur_word, slot_wdata_i, slot_wstrb_i);
  end

  assign slot_rdata_o = cur_word;

  always_ff @(posedge clk_125) begin
    if (sys_rst) begin
      pending <= '0;
      for (int i = 0; i < NUM_SLOTS; i++) slot_q[i] <= '0;
    end else begin
      // new requests are kept even when their slot is stamped this cycle
      pending <= (pending & ~stamp_sel) | time_req_i;
      for (int i = 0; i < NUM_SLOTS; i++) begin
        if (stamp_sel[i]) begin
          slot_q[i] <= stamp_val;
        end else if (slot_wr_i && (slot_idx_i == i)) begin
          if (slot_hi_i) slot_q[i][LOCAL_TIME_W-1:32] <= merged_word[LOCAL_TIME_W-33:0];
          else slot_q[i][31:0] <= merged_word;
        end
      end
    end
  end

endmodule

//--- hdl/ethpipe_ctrl_top.sv
module ethpipe_ctrl_top
  import ethpipe_pkg::*;
#(
  parameter int                      NUM_SLOTS   = 7,
  parameter logic [LOCAL_TIME_W-1:0] CAPTURE_ADJ = 48'd3
) (
  input  logic                  clk_125,
  input  logic                  sys_rst,
  // AXI4-Lite slave
  input  logic [AXI_ADDR_W-1:0] axil_awaddr_i,
  input  logic                  axil_awvalid_i,
  output logic                  axil_awready_o,
  input  logic [AXI_DATA_W-1:0] axil_wdata_i,
  input  logic [AXI_STRB_W-1:0] axil_wstrb_i,
  input  logic                  axil_wvalid_i,
  output logic                  axil_wready_o,
  output logic [1:0]            axil_bresp_o,
  output logic                  axil_bvalid_o,
  input  logic                  axil_bready_i,
  input  logic [AXI_ADDR_W-1:0] axil_araddr_i,
  input  logic                  axil_arvalid_i,
  output logic                  axil_arready_o,
  output logic [AXI_DATA_W-1:0] axil_rdata_o,
  output logic [1:0]            axil_rresp_o,
  output logic                  axil_rvalid_o,
  input  logic                  axil_rready_i,
  // pipe side
  input  logic                  rx_event_i,
  input  logic [TX_PTR_W-1:0]   tx_rd_ptr_i,
  input  logic [NUM_SLOTS-1:0]  time_req_i,
  output logic [DMA_LEN_W-1:0]  dma_length_o,
  output logic [DMA_ADDR_W-1:0] dma_start_o,
  output logic                  dma_load_o,
  output logic [TX_PTR_W-1:0]   tx_wr_ptr_o,
  output logic                  sys_intr_o
);

  logic                  reg_wr;
  logic                  reg_rd;
  logic [AXI_ADDR_W-1:0] reg_addr;
  logic [AXI_DATA_W-1:0] reg_wdata;
  logic [AXI_STRB_W-1:0] reg_wstrb;
  logic [AXI_DATA_W-1:0] reg_rdata;
  logic [COUNTER_W-1:0]  count;
  logic                  slot_wr;
  logic [SLOT_IDX_W-1:0] slot_idx;
  logic                  slot_hi;
  logic [AXI_DATA_W-1:0] slot_wdata;
  logic [AXI_STRB_W-1:0] slot_wstrb;
  logic [AXI_DATA_W-1:0] slot_rdata;

  axil_slave_fsm axil_slave_fsm_i (
    .clk_125(clk_125), .sys_rst(sys_rst),
    .axil_awaddr_i(axil_awaddr_i), .axil_awvalid_i(axil_awvalid_i),
    .axil_awready_o(axil_awready_o),
    .axil_wdata_i(axil_wdata_i), .axil_wstrb_i(axil_wstrb_i),
    .axil_wvalid_i(axil_wvalid_i), .axil_wready_o(axil_wready_o),
    .axil_bresp_o(axil_bresp_o), .axil_bvalid_o(axil_bvalid_o),
    .axil_bready_i(axil_bready_i),
    .axil_araddr_i(axil_araddr_i), .axil_arvalid_i(axil_arvalid_i),
    .axil_arready_o(axil_arready_o),
    .axil_rdata_o(axil_rdata_o), .axil_rresp_o(axil_rresp_o),
    .axil_rvalid_o(axil_rvalid_o), .axil_rready_i(axil_rready_i),
    .reg_wr_o(reg_wr), .reg_rd_o(reg_rd), .reg_addr_o(reg_addr),
    .reg_wdata_o(reg_wdata), .reg_wstrb_o(reg_wstrb), .reg_rdata_i(reg_rdata)
  );

  global_timer global_timer_i (
    .clk_125(clk_125), .sys_rst(sys_rst), .count_o(count)
  );

  ctrl_regs #(.NUM_SLOTS(NUM_SLOTS)) ctrl_regs_i (
    .clk_125(clk_125), .sys_rst(sys_rst),
    .reg_wr_i(reg_wr), .reg_rd_i(reg_rd), .reg_addr_i(reg_addr),
    .reg_wdata_i(reg_wdata), .reg_wstrb_i(reg_wstrb), .reg_rdata_o(reg_rdata),
    .count_i(count), .rx_event_i(rx_event_i), .tx_rd_ptr_i(tx_rd_ptr_i),
    .slot_wr_o(slot_wr), .slot_idx_o(slot_idx), .slot_hi_o(slot_hi),
    .slot_wdata_o(slot_wdata), .slot_wstrb_o(slot_wstrb), .slot_rdata_i(slot_rdata),
    .dma_length_o(dma_length_o), .dma_start_o(dma_start_o), .dma_load_o(dma_load_o),
    .tx_wr_ptr_o(tx_wr_ptr_o), .sys_intr_o(sys_intr_o)
  );

  local_time_capture #(
    .NUM_SLOTS(NUM_SLOTS),
    .CAPTURE_ADJ(CAPTURE_ADJ)
  ) local_time_capture_i (
    .clk_125(clk_125), .sys_rst(sys_rst),
    .count_i(count), .time_req_i(time_req_i),
    .slot_wr_i(slot_wr), .slot_idx_i(slot_idx), .slot_hi_i(slot_hi),
    .slot_wdata_i(slot_wdata), .slot_wstrb_i(slot_wstrb), .slot_rdata_o(slot_rdata)
  );

endmodule

//--- tb/ethpipe_ctrl_asserts.sv
module ethpipe_ctrl_asserts
  import ethpipe_pkg::*;
(
  input logic                  clk_125,
  input logic                  sys_rst,
  input logic                  axil_bvalid_o,
  input logic                  axil_bready_i,
  input logic                  axil_rvalid_o,
  input logic                  axil_rready_i,
  input logic [AXI_DATA_W-1:0] axil_rdata_o,
  input logic                  rx_event_i,
  input logic                  sys_intr_o
);

  timeunit 1ns;
  timeprecision 100ps;

  // ------------------------------------------------------------------------
  // response channel handshake
  // ------------------------------------------------------------------------
  bvalid_hold: assert property (@(posedge clk_125) disable iff (sys_rst)
    axil_bvalid_o && !axil_bready_i |=> axil_bvalid_o)
    else $error("write response valid dropped before bready");

  rvalid_hold: assert property (@(posedge clk_125) disable iff (sys_rst)
    axil_rvalid_o && !axil_rready_i |=> axil_rvalid_o)
    else $error("read response valid dropped before rready");

  rdata_stable: assert property (@(posedge clk_125) disable iff (sys_rst)
    axil_rvalid_o && !axil_rready_i |=> $stable(axil_rdata_o))
    else $error("read data changed while waiting for rready");

  // first cycle out of reset
  no_resp_after_rst: assert property (@(posedge clk_125)
    $fell(sys_rst) |-> !axil_bvalid_o && !axil_rvalid_o)
    else $error("response valid high right after reset");

  // receive event sets the status bit that drives the interrupt
  intr_on_rx_event: assert property (@(posedge clk_125) disable iff (sys_rst)
    rx_event_i |=> sys_intr_o)
    else $error("interrupt not raised after a receive event");

endmodule

bind ethpipe_ctrl_top ethpipe_ctrl_asserts ethpipe_ctrl_asserts_i (
  .clk_125(clk_125),
  .sys_rst(sys_rst),
  .axil_bvalid_o(axil_bvalid_o),
  .axil_bready_i(axil_bready_i),
  .axil_rvalid_o(axil_rvalid_o),
  .axil_rready_i(axil_rready_i),
  .axil_rdata_o(axil_rdata_o),
  .rx_event_i(rx_event_i),
  .sys_intr_o(sys_intr_o)
);

//--- tb/tb_ethpipe_ctrl.sv
module tb_ethpipe_ctrl
  import ethpipe_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int                      NUM_SLOTS   = 7;
  localparam logic [LOCAL_TIME_W-1:0] CAPTURE_ADJ = 48'd3;
  localparam int                      WAIT_LIMIT  = 100;
  localparam logic [AXI_ADDR_W-1:0]   UNMAPPED [7] = '{8'h14, 8'h20, 8'h44, 8'h7C,
                                                       8'hB8, 8'hC4, 8'hFC};

  logic                  clk_125;
  logic                  sys_rst;
  logic [AXI_ADDR_W-1:0] axil_awaddr_i;
  logic                  axil_awvalid_i;
  logic                  axil_awready_o;
  logic [AXI_DATA_W-1:0] axil_wdata_i;
  logic [AXI_STRB_W-1:0] axil_wstrb_i;
  logic                  axil_wvalid_i;
  logic                  axil_wready_o;
  logic [1:0]            axil_bresp_o;
  logic                  axil_bvalid_o;
  logic                  axil_bready_i;
  logic [AXI_ADDR_W-1:0] axil_araddr_i;
  logic                  axil_arvalid_i;
  logic                  axil_arready_o;
  logic [AXI_DATA_W-1:0] axil_rdata_o;
  logic [1:0]            axil_rresp_o;
  logic                  axil_rvalid_o;
  logic                  axil_rready_i;
  logic                  rx_event_i;
  logic [TX_PTR_W-1:0]   tx_rd_ptr_i;
  logic [NUM_SLOTS-1:0]  time_req_i;
  logic [DMA_LEN_W-1:0]  dma_length_o;
  logic [DMA_ADDR_W-1:0] dma_start_o;
  logic                  dma_load_o;
  logic [TX_PTR_W-1:0]   tx_wr_ptr_o;
  logic                  sys_intr_o;

  integer                seed;
  int                    err_cnt;
  logic [COUNTER_W-1:0]  cyc;
  // status, length, start and write pointer registers
  logic [AXI_ADDR_W-1:0] cfg_addr  [4];
  logic [AXI_DATA_W-1:0] cfg_mask  [4];
  logic [AXI_DATA_W-1:0] cfg_model [4];

  ethpipe_ctrl_top #(
    .NUM_SLOTS(NUM_SLOTS),
    .CAPTURE_ADJ(CAPTURE_ADJ)
  ) ethpipe_ctrl_top_i (.*);

  initial clk_125 = 1'b0;
  always #4 clk_125 = ~clk_125;

  // model cycle count since reset release
  always @(posedge clk_125) begin
    if (sys_rst) cyc <= '0;
    else cyc <= cyc + 1'b1;
  end

  // --------------------------------------------------------------------------
  // checking helpers
  // --------------------------------------------------------------------------
  task automatic abort_run(input string msg);
    err_cnt++;
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_word(input string name, input logic [AXI_DATA_W-1:0] exp,
                            input logic [AXI_DATA_W-1:0] act);
    if (act !== exp) abort_run($sformatf("FAILED %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_count(input string name, input logic [COUNTER_W-1:0] exp,
                             input logic [COUNTER_W-1:0] act);
    if (act !== exp) abort_run($sformatf("FAILED %s expected %0d actual %0d", name, exp, act));
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) abort_run($sformatf("FAILED %s expected %b actual %b", name, exp, act));
  endtask

  task automatic check_window(input string name, input logic [COUNTER_W-1:0] lo,
                              input logic [COUNTER_W-1:0] hi, input logic [COUNTER_W-1:0] act);
    if (act < lo || act > hi) begin
      abort_run($sformatf("FAILED %s expected %0d..%0d actual %0d", name, lo, hi, act));
    end
  endtask

  function automatic logic [AXI_DATA_W-1:0] merge_lanes(input logic [AXI_DATA_W-1:0] old_w,
                                                        input logic [AXI_DATA_W-1:0] new_w,
                                                        input logic [AXI_STRB_W-1:0] strb);
    logic [AXI_DATA_W-1:0] mask;
    mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  // master ready is high three times out of four
  function automatic logic ready_draw();
    return ($random(seed) & 3) != 0;
  endfunction

  function automatic logic [AXI_ADDR_W-1:0] slot_addr(input int slot, input logic hi);
    logic [AXI_ADDR_W-1:0] off;
    off = AXI_ADDR_W'(slot * 8);
    if (hi) off = off + 8'd4;
    return REG_LOCAL_TIME_BASE + off;
  endfunction

  // --------------------------------------------------------------------------
  // AXI4-Lite master
  // --------------------------------------------------------------------------
  task automatic bus_write(input logic [AXI_ADDR_W-1:0] addr, input logic [AXI_DATA_W-1:0] data,
                           input logic [AXI_STRB_W-1:0] strb, input logic exp_load);
    int n;
    n = 0;
    @(posedge clk_125);
    #1;
    axil_awaddr_i  = addr;
    axil_wdata_i   = data;
    axil_wstrb_i   = strb;
    axil_awvalid_i = 1'b1;
    axil_wvalid_i  = 1'b1;
    @(negedge clk_125);
    while (!(axil_awready_o && axil_wready_o)) begin
      n++;
      if (n > WAIT_LIMIT) abort_run("write was never accepted by the DUT");
      @(negedge clk_125);
    end
    @(posedge clk_125);
    #1;
    axil_awvalid_i = 1'b0;
    axil_wvalid_i  = 1'b0;
    axil_bready_i  = ready_draw();
    @(negedge clk_125);
    check_bit("bvalid_latency", 1'b1, axil_bvalid_o);
    check_bit("dma_load_pulse", exp_load, dma_load_o);
    n = 0;
    while (!(axil_bvalid_o && axil_bready_i)) begin
      n++;
      if (n > WAIT_LIMIT) abort_run("write response never completed");
      @(posedge clk_125);
      #1;
      axil_bready_i = ready_draw();
      @(negedge clk_125);
    end
    check_word("bresp", 32'(RESP_OKAY), 32'(axil_bresp_o));
    @(posedge clk_125);
    #1;
    axil_bready_i = 1'b0;
    @(negedge clk_125);
    check_bit("dma_load_single", 1'b0, dma_load_o);
  endtask

  task automatic bus_read(input logic [AXI_ADDR_W-1:0] addr,
                          output logic [AXI_DATA_W-1:0] data,
                          output logic [COUNTER_W-1:0] acc_cyc);
    int n;
    n = 0;
    @(posedge clk_125);
    #1;
    axil_araddr_i  = addr;
    axil_arvalid_i = 1'b1;
    @(negedge clk_125);
    while (!axil_arready_o) begin
      n++;
      if (n > WAIT_LIMIT) abort_run("read was never accepted by the DUT");
      @(negedge clk_125);
    end
    acc_cyc = cyc;
    @(posedge clk_125);
    #1;
    axil_arvalid_i = 1'b0;
    axil_rready_i  = ready_draw();
    @(negedge clk_125);
    check_bit("rvalid_latency", 1'b1, axil_rvalid_o);
    n = 0;
    while (!(axil_rvalid_o && axil_rready_i)) begin
      n++;
      if (n > WAIT_LIMIT) abort_run("read response never completed");
      @(posedge clk_125);
      #1;
      axil_rready_i = ready_draw();
      @(negedge clk_125);
    end
    data = axil_rdata_o;
    check_word("rresp", 32'(RESP_OKAY), 32'(axil_rresp_o));
    @(posedge clk_125);
    #1;
    axil_rready_i = 1'b0;
  endtask

  task automatic read_expect(input string name, input logic [AXI_ADDR_W-1:0] addr,
                             input logic [AXI_DATA_W-1:0] exp);
    logic [AXI_DATA_W-1:0] data;
    logic [COUNTER_W-1:0]  acc;
    bus_read(addr, data, acc);
    check_word(name, exp, data);
  endtask

  task automatic check_dma_outputs();
    check_word("dma_length_o", cfg_model[1], 32'(dma_length_o));
    check_word("dma_start_o", cfg_model[2], 32'(dma_start_o));
    check_word("tx_wr_ptr_o", cfg_model[3], 32'(tx_wr_ptr_o));
  endtask

  // --------------------------------------------------------------------------
  // test sequence
  // --------------------------------------------------------------------------
  initial begin
    int                    sel;
    int                    slot;
    int                    rank;
    logic [AXI_DATA_W-1:0] data;
    logic [AXI_STRB_W-1:0] strb;
    logic [AXI_DATA_W-1:0] d1;
    logic [AXI_DATA_W-1:0] d2;
    logic [AXI_DATA_W-1:0] lo;
    logic [AXI_DATA_W-1:0] hi;
    logic [COUNTER_W-1:0]  c1;
    logic [COUNTER_W-1:0]  c2;
    logic [COUNTER_W-1:0]  req_cyc;
    logic [NUM_SLOTS-1:0]  req;
    seed           = 81;
    err_cnt        = 0;
    sys_rst        = 1'b1;
    axil_awaddr_i  = '0;
    axil_awvalid_i = 1'b0;
    axil_wdata_i   = '0;
    axil_wstrb_i   = '0;
    axil_wvalid_i  = 1'b0;
    axil_bready_i  = 1'b0;
    axil_araddr_i  = '0;
    axil_arvalid_i = 1'b0;
    axil_rready_i  = 1'b0;
    rx_event_i     = 1'b0;
    tx_rd_ptr_i    = '0;
    time_req_i     = '0;
    cfg_addr       = '{REG_DMA_STATUS, REG_DMA_LENGTH, REG_DMA_START, REG_TX_WR_PTR};
    cfg_mask       = '{32'h0000_00FF, 32'h003F_FFFC, 32'hFFFF_FFFC, 32'h0000_3FFF};
    cfg_model      = '{32'h0, 32'(DMA_LENGTH_RST), DMA_START_RST, 32'h0};
    repeat (8) @(posedge clk_125);
    #1;
    sys_rst = 1'b0;
    @(negedge clk_125);
    check_dma_outputs();
    check_bit("dma_load_rst", 1'b0, dma_load_o);
    check_bit("sys_intr_rst", 1'b0, sys_intr_o);

    // random strobed writes each read back
    for (int i = 0; i < 40; i++) begin
      sel  = {$random(seed)} % 4;
      data = $random(seed);
      strb = $random(seed);
      cfg_model[sel] = merge_lanes(cfg_model[sel], data, strb) & cfg_mask[sel];
      bus_write(cfg_addr[sel], data, strb, sel == 1 || sel == 2);
      check_dma_outputs();
      check_bit("sys_intr_o", cfg_model[0][STATUS_RX_EVENT_BIT], sys_intr_o);
      read_expect("cfg_readback", cfg_addr[sel], cfg_model[sel]);
    end

    // counter delta across two reads
    bus_read(REG_COUNTER_LO, d1, c1);
    repeat (({$random(seed)} % 8) + 1) @(posedge clk_125);
    bus_read(REG_COUNTER_LO, d2, c2);
    check_count("counter_delta", c2 - c1, 64'(d2 - d1));
    read_expect("counter_hi", REG_COUNTER_HI, 32'h0);

    // receive event and interrupt
    @(posedge clk_125);
    #1;
    rx_event_i = 1'b1;
    @(posedge clk_125);
    #1;
    rx_event_i = 1'b0;
    @(negedge clk_125);
    check_bit("intr_set", 1'b1, sys_intr_o);
    cfg_model[0][STATUS_RX_EVENT_BIT] = 1'b1;
    read_expect("status_rx", REG_DMA_STATUS, cfg_model[0]);
    bus_write(REG_DMA_STATUS, 32'h0, 4'h1, 1'b0);
    cfg_model[0] = 32'h0;
    check_bit("intr_clear", 1'b0, sys_intr_o);

    // unmapped offsets and the hardware read pointer
    bus_write(8'h14, $random(seed), 4'hF, 1'b0);
    check_dma_outputs();
    for (int i = 0; i < 7; i++) read_expect("unmapped", UNMAPPED[i], 32'h0);
    tx_rd_ptr_i = $random(seed);
    read_expect("tx_rd_ptr", REG_TX_RD_PTR, 32'(tx_rd_ptr_i));

    // hardware stamping takes the lowest pending slot first
    for (int r = 0; r < 4; r++) begin
      req = $random(seed);
      if (req == '0) req = 1;
      @(posedge clk_125);
      #1;
      time_req_i = req;
      @(negedge clk_125);
      req_cyc = cyc;
      @(posedge clk_125);
      #1;
      time_req_i = '0;
      repeat (12) @(posedge clk_125);
      rank = 0;
      for (int s = 0; s < NUM_SLOTS; s++) begin
        if (req[s]) begin
          bus_read(slot_addr(s, 1'b0), lo, c1);
          bus_read(slot_addr(s, 1'b1), hi, c1);
          check_word("slot_hi_pad", 32'h0, {hi[31:16], 16'h0});
          check_window("slot_stamp", req_cyc - 64'(CAPTURE_ADJ), req_cyc + 64'(rank),
                       {16'h0, hi[15:0], lo});
          rank++;
        end
      end
    end

    // software slot writes with full then partial strobes
    for (int i = 0; i < 6; i++) begin
      slot = {$random(seed)} % NUM_SLOTS;
      lo   = $random(seed);
      hi   = $random(seed) & 32'h0000_FFFF;
      bus_write(slot_addr(slot, 1'b0), lo, 4'hF, 1'b0);
      bus_write(slot_addr(slot, 1'b1), hi, 4'hF, 1'b0);
      data = $random(seed);
      strb = $random(seed);
      lo   = merge_lanes(lo, data, strb);
      bus_write(slot_addr(slot, 1'b0), data, strb, 1'b0);
      data = $random(seed);
      strb = $random(seed);
      hi   = merge_lanes(hi, data, strb) & 32'h0000_FFFF;
      bus_write(slot_addr(slot, 1'b1), data, strb, 1'b0);
      read_expect("slot_sw_lo", slot_addr(slot, 1'b0), lo);
      read_expect("slot_sw_hi", slot_addr(slot, 1'b1), hi);
    end

    if (err_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- sim.f
hdl/ethpipe_pkg.sv
hdl/global_timer.sv
hdl/axil_slave_fsm.sv
hdl/ctrl_regs.sv
hdl/local_time_capture.sv
hdl/ethpipe_ctrl_top.sv
tb/ethpipe_ctrl_asserts.sv
tb/tb_ethpipe_ctrl.sv

//--- Makefile
TOP = tb_ethpipe_ctrl

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
	  --top-module $(TOP) -f sim.f -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	if grep -q "TEST FAILED" sim.log; then exit 1; fi; exit $$status

clean:
	rm -rf obj_dir sim.log
